// ==== rtl/dmmu_macros.svh ====
/*
 Data MMU size, field and address definitions.
 Shared by the RTL and the test files so both agree on SPR addresses,
 page-table-entry bit positions and translate-entry bit positions.
*/

`ifndef DMMU_MACROS_SVH
`define DMMU_MACROS_SVH

// TLB geometry
`define DMMU_SET_WIDTH   6
`define DMMU_PAGE_BITS   13

// SPR map
`define DMMU_SPR_GROUP   5'd1
`define DMMU_DMMUCR_ADDR 16'h0800
`define DMMU_MATCH_BASE  16'h0A00
`define DMMU_TRANS_BASE  16'h0A80

// Page-table entry bits
`define DMMU_PTE_PRESENT 10
`define DMMU_PTE_W       7
`define DMMU_PTE_U       6

// Translate entry bits
`define DMMU_TR_SWE      9
`define DMMU_TR_SRE      8
`define DMMU_TR_UWE      7
`define DMMU_TR_URE      6
`define DMMU_TR_CI       1

`endif

// ==== rtl/dmmu_pkg.sv ====
/*
 Data MMU types.
 Reload walker states, SPR access targets and the common word and
 set-index types used across the datapath.
*/

`default_nettype none

`include "dmmu_macros.svh"

package dmmu_pkg;

   typedef logic [31:0]                  dmmu_word_t;
   typedef logic [`DMMU_SET_WIDTH-1:0]   dmmu_set_t;

   // Hardware reload walk
   typedef enum logic [1:0] {
      RELOAD_IDLE,
      RELOAD_GET_PTR,
      RELOAD_GET_PTE,
      RELOAD_SETTLE
   } reload_state_e;

   // What an SPR access selects
   typedef enum logic [1:0] {
      SPR_NONE,
      SPR_MATCH,
      SPR_TRANS,
      SPR_CTRL
   } spr_target_e;

endpackage

`default_nettype wire

// ==== rtl/dmmu_tlb_ram.sv ====
/*
 TLB array, one per entry kind.
 64 words with a registered read and a single write port. A write
 also appears on the read output after the edge, so a refilled entry
 is visible on the very next cycle.
*/

`timescale 1ns/100ps
`default_nettype none

`include "dmmu_macros.svh"

module dmmu_tlb_ram (
   input  wire                        clk,
   input  wire [`DMMU_SET_WIDTH-1:0]  addr_i,
   input  wire                        we_i,
   input  wire [31:0]                 din_i,
   output logic [31:0]                dout_o
);

   localparam int DEPTH = 1 << `DMMU_SET_WIDTH;

   logic [31:0] mem [DEPTH];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[addr_i] <= din_i;
         // Write-through on the read port
         dout_o      <= din_i;
      end else begin
         dout_o      <= mem[addr_i];
      end
   end

endmodule

`default_nettype wire

// ==== rtl/dmmu_spr_if.sv ====
/*
 SPR bus front end of the data MMU.
 Decodes the access target, acks on the second strobe cycle, holds
 DMMUCR, steers the shared TLB address between SPR and lookup, merges
 refill writes over SPR writes and muxes the read-back data.
*/

`timescale 1ns/100ps
`default_nettype none

`include "dmmu_macros.svh"

module dmmu_spr_if
   import dmmu_pkg::*;
(
   input  wire               clk,
   input  wire               rst,
   input  wire [15:0]        spr_addr_i,
   input  wire               spr_we_i,
   input  wire               spr_stb_i,
   input  wire dmmu_word_t   spr_dat_i,
   output dmmu_word_t        spr_dat_o,
   output logic              spr_ack_o,
   input  wire dmmu_word_t   virt_addr_i,
   input  wire               refill_we_i,
   input  wire dmmu_word_t   match_refill_i,
   input  wire dmmu_word_t   trans_refill_i,
   input  wire dmmu_word_t   match_dout_i,
   input  wire dmmu_word_t   trans_dout_i,
   output dmmu_set_t         ram_addr_o,
   output logic              match_we_o,
   output logic              trans_we_o,
   output dmmu_word_t        match_din_o,
   output dmmu_word_t        trans_din_o,
   output logic [21:0]       dmmucr_base_o
);

   spr_target_e spr_target;
   spr_target_e spr_target_r;
   logic        group_sel;
   logic        ram_sel;
   logic        ack_r;
   dmmu_word_t  dmmucr;

   assign group_sel = spr_stb_i && (spr_addr_i[15:11] == `DMMU_SPR_GROUP);

   always_comb begin
      spr_target = SPR_NONE;
      if (spr_stb_i) begin
         if (spr_addr_i == `DMMU_DMMUCR_ADDR)
            spr_target = SPR_CTRL;
         else if ((spr_addr_i >> `DMMU_SET_WIDTH) == (`DMMU_MATCH_BASE >> `DMMU_SET_WIDTH))
            spr_target = SPR_MATCH;
         else if ((spr_addr_i >> `DMMU_SET_WIDTH) == (`DMMU_TRANS_BASE >> `DMMU_SET_WIDTH))
            spr_target = SPR_TRANS;
      end
   end

   // Ack on the second strobe cycle, never twice in a row
   always_ff @(posedge clk) begin
      if (rst) begin
         ack_r        <= 1'b0;
         spr_target_r <= SPR_NONE;
         dmmucr       <= '0;
      end else begin
         ack_r        <= group_sel && !spr_ack_o;
         spr_target_r <= spr_target;
         if (spr_target == SPR_CTRL && spr_we_i)
            dmmucr <= spr_dat_i;
      end
   end

   assign spr_ack_o     = ack_r && group_sel;
   assign dmmucr_base_o = dmmucr[31:10];

   // Refill owns the address and data when it writes
   assign ram_sel     = (spr_target == SPR_MATCH || spr_target == SPR_TRANS) && !refill_we_i;
   assign ram_addr_o  = ram_sel ? spr_addr_i[`DMMU_SET_WIDTH-1:0]
                                : virt_addr_i[`DMMU_PAGE_BITS +: `DMMU_SET_WIDTH];
   assign match_we_o  = refill_we_i || (spr_we_i && spr_target == SPR_MATCH);
   assign trans_we_o  = refill_we_i || (spr_we_i && spr_target == SPR_TRANS);
   assign match_din_o = refill_we_i ? match_refill_i : spr_dat_i;
   assign trans_din_o = refill_we_i ? trans_refill_i : spr_dat_i;

   always_comb begin
      case (spr_target_r)
         SPR_MATCH: spr_dat_o = match_dout_i;
         SPR_TRANS: spr_dat_o = trans_dout_i;
         SPR_CTRL:  spr_dat_o = dmmucr;
         default:   spr_dat_o = '0;
      endcase
   end

   // The read-back mux relies on the address held over both strobe cycles
   a_ack_needs_held_stb: assert property (@(posedge clk) disable iff (rst)
      spr_ack_o |-> spr_stb_i && $past(spr_stb_i) && $stable(spr_addr_i));

endmodule

`default_nettype wire

// ==== rtl/dmmu_lookup.sv ====
/*
 TLB lookup, second stage.
 Compares the match entry against the virtual page, forms the
 physical address and cache-inhibit flag, and raises a page fault
 when the access lacks the needed permission.
*/

`timescale 1ns/100ps
`default_nettype none

`include "dmmu_macros.svh"

module dmmu_lookup
   import dmmu_pkg::*;
(
   input  wire dmmu_word_t  virt_addr_match_i,
   input  wire dmmu_word_t  match_dout_i,
   input  wire dmmu_word_t  trans_dout_i,
   input  wire              op_load_i,
   input  wire              op_store_i,
   input  wire              supervisor_mode_i,
   input  wire              reload_busy_i,
   output logic             tlb_miss_o,
   output dmmu_word_t       phys_addr_o,
   output logic             cache_inhibit_o,
   output logic             pagefault_o
);

   logic hit;
   logic swe;
   logic sre;
   logic uwe;
   logic ure;
   logic fault;

   // Valid bit and VPN compare
   assign hit = match_dout_i[0] &&
                (match_dout_i[31:`DMMU_PAGE_BITS] == virt_addr_match_i[31:`DMMU_PAGE_BITS]);

   assign tlb_miss_o = !hit;

   always_comb begin
      phys_addr_o = '0;
      phys_addr_o[`DMMU_PAGE_BITS-1:0] = virt_addr_match_i[`DMMU_PAGE_BITS-1:0];
      cache_inhibit_o = 1'b0;
      swe = 1'b0;
      sre = 1'b0;
      uwe = 1'b0;
      ure = 1'b0;
      if (hit) begin
         phys_addr_o[31:`DMMU_PAGE_BITS] = trans_dout_i[31:`DMMU_PAGE_BITS];
         cache_inhibit_o = trans_dout_i[`DMMU_TR_CI];
         swe = trans_dout_i[`DMMU_TR_SWE];
         sre = trans_dout_i[`DMMU_TR_SRE];
         uwe = trans_dout_i[`DMMU_TR_UWE];
         ure = trans_dout_i[`DMMU_TR_URE];
      end
   end

   assign fault = supervisor_mode_i ? ((op_store_i && !swe) || (op_load_i && !sre))
                                    : ((op_store_i && !uwe) || (op_load_i && !ure));

   // Hidden while the walker is still filling the entry
   assign pagefault_o = fault && !reload_busy_i;

endmodule

`default_nettype wire

// ==== rtl/dmmu_reload_ctrl.sv ====
/*
 Hardware TLB reload walker.
 On a miss it fetches the page-table pointer and then the PTE over a
 request/acknowledge port, writes the match and translate entries,
 and waits one settle cycle. Bad pointers and absent pages set a
 sticky fault flag instead.
*/

`timescale 1ns/100ps
`default_nettype none

`include "dmmu_macros.svh"

module dmmu_reload_ctrl
   import dmmu_pkg::*;
(
   input  wire               clk,
   input  wire               rst,
   input  wire               enable_i,
   input  wire               op_load_i,
   input  wire               op_store_i,
   input  wire               tlb_miss_i,
   input  wire dmmu_word_t   virt_addr_match_i,
   input  wire [21:0]        dmmucr_base_i,
   output logic              reload_req_o,
   output dmmu_word_t        reload_addr_o,
   input  wire               reload_ack_i,
   input  wire dmmu_word_t   reload_data_i,
   output logic              reload_busy_o,
   output logic              reload_pagefault_o,
   input  wire               reload_pagefault_clear_i,
   output logic              refill_we_o,
   output dmmu_word_t        match_refill_o,
   output dmmu_word_t        trans_refill_o
);

   reload_state_e state;
   logic          base_nz;
   logic          abort;
   logic          do_reload;
   logic          ptr_bad;
   logic          pf_flag;
   dmmu_word_t    trans_entry;

   assign base_nz   = (dmmucr_base_i != '0);
   assign abort     = !enable_i || !base_nz;
   assign do_reload = (state == RELOAD_IDLE) && enable_i && base_nz && tlb_miss_i &&
                      (op_load_i || op_store_i) && !pf_flag;

   // Covers the miss cycle itself as well as the walk
   assign reload_busy_o      = ((state != RELOAD_IDLE) && !abort) || do_reload;
   assign reload_pagefault_o = pf_flag && !reload_pagefault_clear_i;

   // Null pointer, or bit 9 set marking a huge page
   assign ptr_bad = (reload_data_i[31:`DMMU_PAGE_BITS] == '0) || reload_data_i[9];

   // PTE to translate entry, U/W mapped onto the four enables
   always_comb begin
      trans_entry = '0;
      trans_entry[31:`DMMU_PAGE_BITS] = reload_data_i[31:`DMMU_PAGE_BITS];
      trans_entry[`DMMU_TR_SWE] = reload_data_i[`DMMU_PTE_W];
      trans_entry[`DMMU_TR_SRE] = 1'b1;
      trans_entry[`DMMU_TR_UWE] = reload_data_i[`DMMU_PTE_W] && reload_data_i[`DMMU_PTE_U];
      trans_entry[`DMMU_TR_URE] = reload_data_i[`DMMU_PTE_U];
      trans_entry[5:0] = reload_data_i[5:0];
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state        <= RELOAD_IDLE;
         reload_req_o <= 1'b0;
         refill_we_o  <= 1'b0;
         pf_flag      <= 1'b0;
      end else begin
         refill_we_o <= 1'b0;
         if (reload_pagefault_clear_i)
            pf_flag <= 1'b0;

         case (state)
            RELOAD_IDLE: begin
               if (do_reload) begin
                  reload_req_o <= 1'b1;
                  state        <= RELOAD_GET_PTR;
               end
            end
            RELOAD_GET_PTR: begin
               if (reload_ack_i) begin
                  if (ptr_bad) begin
                     pf_flag      <= 1'b1;
                     reload_req_o <= 1'b0;
                     state        <= RELOAD_IDLE;
                  end else begin
                     state <= RELOAD_GET_PTE;
                  end
               end
            end
            RELOAD_GET_PTE: begin
               if (reload_ack_i) begin
                  reload_req_o <= 1'b0;
                  if (!reload_data_i[`DMMU_PTE_PRESENT]) begin
                     pf_flag <= 1'b1;
                     state   <= RELOAD_IDLE;
                  end else begin
                     refill_we_o <= 1'b1;
                     state       <= RELOAD_SETTLE;
                  end
               end
            end
            RELOAD_SETTLE: begin
               // First cycle writes, second lets the RAM output settle
               if (!refill_we_o)
                  state <= RELOAD_IDLE;
            end
            default: state <= RELOAD_IDLE;
         endcase

         if (abort) begin
            state        <= RELOAD_IDLE;
            reload_req_o <= 1'b0;
            refill_we_o  <= 1'b0;
         end
      end
   end

   // Walk addresses and refill words
   always_ff @(posedge clk) begin
      if (do_reload)
         reload_addr_o <= {dmmucr_base_i, virt_addr_match_i[31:24], 2'b00};
      else if (state == RELOAD_GET_PTR && reload_ack_i)
         reload_addr_o <= {reload_data_i[31:13], virt_addr_match_i[23:13], 2'b00};
      if (state == RELOAD_GET_PTE && reload_ack_i) begin
         trans_refill_o <= trans_entry;
         match_refill_o <= {virt_addr_match_i[31:`DMMU_PAGE_BITS], 12'd0, 1'b1};
      end
   end

   a_req_low_when_quiet: assert property (@(posedge clk) disable iff (rst)
      (state == RELOAD_IDLE || state == RELOAD_SETTLE) |-> !reload_req_o);

   a_refill_single_pulse: assert property (@(posedge clk) disable iff (rst)
      refill_we_o |=> !refill_we_o);

endmodule

`default_nettype wire

// ==== rtl/dmmu_top.sv ====
/*
 Data MMU top level.
 Direct-mapped 64-set TLB with 8 KB pages, SPR access to the entries
 and DMMUCR, a two-stage lookup and a hardware page-table walker.
*/

`timescale 1ns/100ps
`default_nettype none

`include "dmmu_macros.svh"

module dmmu_top
   import dmmu_pkg::*;
(
   input  wire          clk,
   input  wire          rst,
   // Core side
   input  wire          enable_i,
   input  wire [31:0]   virt_addr_i,
   input  wire [31:0]   virt_addr_match_i,
   input  wire          op_load_i,
   input  wire          op_store_i,
   input  wire          supervisor_mode_i,
   output logic [31:0]  phys_addr_o,
   output logic         cache_inhibit_o,
   output logic         tlb_miss_o,
   output logic         pagefault_o,
   // SPR bus
   input  wire [15:0]   spr_addr_i,
   input  wire          spr_we_i,
   input  wire          spr_stb_i,
   input  wire [31:0]   spr_dat_i,
   output logic [31:0]  spr_dat_o,
   output logic         spr_ack_o,
   // Reload memory port and status
   output logic         reload_req_o,
   output logic [31:0]  reload_addr_o,
   input  wire          reload_ack_i,
   input  wire [31:0]   reload_data_i,
   output logic         reload_busy_o,
   output logic         reload_pagefault_o,
   input  wire          reload_pagefault_clear_i
);

   dmmu_set_t   ram_addr;
   dmmu_word_t  match_dout;
   dmmu_word_t  trans_dout;
   dmmu_word_t  match_din;
   dmmu_word_t  trans_din;
   logic        match_we;
   logic        trans_we;
   logic [21:0] dmmucr_base;
   logic        refill_we;
   dmmu_word_t  match_refill;
   dmmu_word_t  trans_refill;

   dmmu_spr_if spr_if0 (
      .clk(clk), .rst(rst),
      .spr_addr_i(spr_addr_i), .spr_we_i(spr_we_i), .spr_stb_i(spr_stb_i),
      .spr_dat_i(spr_dat_i), .spr_dat_o(spr_dat_o), .spr_ack_o(spr_ack_o),
      .virt_addr_i(virt_addr_i),
      .refill_we_i(refill_we), .match_refill_i(match_refill), .trans_refill_i(trans_refill),
      .match_dout_i(match_dout), .trans_dout_i(trans_dout),
      .ram_addr_o(ram_addr), .match_we_o(match_we), .trans_we_o(trans_we),
      .match_din_o(match_din), .trans_din_o(trans_din),
      .dmmucr_base_o(dmmucr_base)
   );

   dmmu_tlb_ram match_ram (
      .clk(clk), .addr_i(ram_addr), .we_i(match_we), .din_i(match_din), .dout_o(match_dout)
   );

   dmmu_tlb_ram trans_ram (
      .clk(clk), .addr_i(ram_addr), .we_i(trans_we), .din_i(trans_din), .dout_o(trans_dout)
   );

   dmmu_lookup lookup0 (
      .virt_addr_match_i(virt_addr_match_i),
      .match_dout_i(match_dout), .trans_dout_i(trans_dout),
      .op_load_i(op_load_i), .op_store_i(op_store_i),
      .supervisor_mode_i(supervisor_mode_i), .reload_busy_i(reload_busy_o),
      .tlb_miss_o(tlb_miss_o), .phys_addr_o(phys_addr_o),
      .cache_inhibit_o(cache_inhibit_o), .pagefault_o(pagefault_o)
   );

   dmmu_reload_ctrl reload0 (
      .clk(clk), .rst(rst),
      .enable_i(enable_i), .op_load_i(op_load_i), .op_store_i(op_store_i),
      .tlb_miss_i(tlb_miss_o), .virt_addr_match_i(virt_addr_match_i),
      .dmmucr_base_i(dmmucr_base),
      .reload_req_o(reload_req_o), .reload_addr_o(reload_addr_o),
      .reload_ack_i(reload_ack_i), .reload_data_i(reload_data_i),
      .reload_busy_o(reload_busy_o), .reload_pagefault_o(reload_pagefault_o),
      .reload_pagefault_clear_i(reload_pagefault_clear_i),
      .refill_we_o(refill_we), .match_refill_o(match_refill), .trans_refill_o(trans_refill)
   );

endmodule

`default_nettype wire

// ==== test/tb_pte_mem.sv ====
/*
 Page-table memory model for the reload port.
 16 KB of words behind a request/acknowledge port. Each request is
 answered after a random wait of 0 to 5 cycles, and the testbench
 loads entries through a separate write port.
*/

`timescale 1ns/100ps
`default_nettype none

module tb_pte_mem (
   input  wire         clk,
   input  wire         rst,
   input  wire         req_i,
   input  wire [31:0]  addr_i,
   output logic        ack_o,
   output logic [31:0] data_o,
   input  wire         wr_en_i,
   input  wire [31:0]  wr_addr_i,
   input  wire [31:0]  wr_data_i
);

   logic [31:0] mem [4096];
   logic [2:0]  delay;
   logic        counting;

   // Fill pattern built from the byte address of each word
   always @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 4096; i++)
            mem[i] <= (32'(i) * 32'd4 * 32'h9E37_79B1) ^ 32'h0F0F_F0F0;
      end else if (wr_en_i) begin
         mem[wr_addr_i[13:2]] <= wr_data_i;
      end
   end

   // Answer on the falling edge so the DUT samples a stable ack
   always @(negedge clk) begin
      if (rst) begin
         ack_o    <= 1'b0;
         data_o   <= '0;
         delay    <= '0;
         counting <= 1'b0;
      end else begin
         ack_o <= 1'b0;
         if (req_i && !ack_o) begin
            if (!counting) begin
               counting <= 1'b1;
               delay    <= 3'($urandom % 6);
            end else if (delay == 3'd0) begin
               counting <= 1'b0;
               ack_o    <= 1'b1;
               // Outside the modelled range the data still follows the address
               data_o   <= (addr_i[31:14] == '0) ? mem[addr_i[13:2]]
                                                 : addr_i ^ 32'h5A5A_A5A5;
            end else begin
               delay <= delay - 3'd1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== test/tb_dmmu.sv ====
/*
 Testbench for the data MMU.
 Drives SPR accesses, two-stage lookups and hardware reload walks,
 keeps reference copies of the TLB and page table, and checks the
 DUT responses with assertions.
*/

`timescale 1ns/100ps
`default_nettype none

`include "dmmu_macros.svh"

module tb_dmmu;

   logic        clk = 1'b0;
   logic        rst;
   logic        enable;
   logic [31:0] virt_addr;
   logic [31:0] virt_addr_match;
   logic        op_load;
   logic        op_store;
   logic        supervisor;
   logic [31:0] phys_addr;
   logic        cache_inhibit;
   logic        tlb_miss;
   logic        pagefault;
   logic [15:0] spr_addr;
   logic        spr_we;
   logic        spr_stb;
   logic [31:0] spr_dat_w;
   logic [31:0] spr_dat_r;
   logic        spr_ack;
   logic        reload_req;
   logic [31:0] reload_addr;
   logic        reload_ack;
   logic [31:0] reload_data;
   logic        reload_busy;
   logic        reload_pf;
   logic        pf_clear;
   logic        mem_we;
   logic [31:0] mem_addr;
   logic [31:0] mem_data;

   // Reference copies of what the testbench has written
   logic [31:0] ref_match [64];
   logic [31:0] ref_trans [64];
   logic [31:0] ref_pt [4096];

   logic        chk_lookup = 1'b0;
   logic        exp_miss;
   logic [31:0] exp_phys;
   logic        exp_ci;
   logic        exp_pf;
   logic        chk_spr = 1'b0;
   logic [31:0] exp_spr;
   logic        chk_noreload = 1'b0;
   logic        chk_walk = 1'b0;
   logic        walk_clear = 1'b0;
   logic [31:0] exp_ptr_addr;
   logic [31:0] exp_pte_addr;
   int          exp_acks;
   int          ack_count;
   logic [21:0] base;
   int          errors = 0;
   int          timeouts = 0;

   always #5 clk = ~clk;

   dmmu_top dut0 (
      .clk(clk), .rst(rst),
      .enable_i(enable), .virt_addr_i(virt_addr), .virt_addr_match_i(virt_addr_match),
      .op_load_i(op_load), .op_store_i(op_store), .supervisor_mode_i(supervisor),
      .phys_addr_o(phys_addr), .cache_inhibit_o(cache_inhibit),
      .tlb_miss_o(tlb_miss), .pagefault_o(pagefault),
      .spr_addr_i(spr_addr), .spr_we_i(spr_we), .spr_stb_i(spr_stb),
      .spr_dat_i(spr_dat_w), .spr_dat_o(spr_dat_r), .spr_ack_o(spr_ack),
      .reload_req_o(reload_req), .reload_addr_o(reload_addr),
      .reload_ack_i(reload_ack), .reload_data_i(reload_data),
      .reload_busy_o(reload_busy), .reload_pagefault_o(reload_pf),
      .reload_pagefault_clear_i(pf_clear)
   );

   tb_pte_mem pte_mem0 (
      .clk(clk), .rst(rst), .req_i(reload_req), .addr_i(reload_addr),
      .ack_o(reload_ack), .data_o(reload_data),
      .wr_en_i(mem_we), .wr_addr_i(mem_addr), .wr_data_i(mem_data)
   );

   // Acks seen during the current walk
   always @(posedge clk) begin
      if (walk_clear)
         ack_count <= 0;
      else if (reload_req && reload_ack)
         ack_count <= ack_count + 1;
   end

   a_miss: assert property (@(posedge clk) disable iff (rst)
      chk_lookup |-> tlb_miss == exp_miss)
      else begin
         errors++;
         $display("Mismatch tlb_miss_o: got %h, expected %h", tlb_miss, exp_miss);
      end

   a_phys: assert property (@(posedge clk) disable iff (rst)
      chk_lookup |-> phys_addr == exp_phys)
      else begin
         errors++;
         $display("Mismatch phys_addr_o: got %h, expected %h", phys_addr, exp_phys);
      end

   a_ci: assert property (@(posedge clk) disable iff (rst)
      chk_lookup |-> cache_inhibit == exp_ci)
      else begin
         errors++;
         $display("Mismatch cache_inhibit_o: got %h, expected %h", cache_inhibit, exp_ci);
      end

   a_pf: assert property (@(posedge clk) disable iff (rst)
      chk_lookup |-> pagefault == exp_pf)
      else begin
         errors++;
         $display("Mismatch pagefault_o: got %h, expected %h", pagefault, exp_pf);
      end

   a_spr_data: assert property (@(posedge clk) disable iff (rst)
      chk_spr && spr_ack |-> spr_dat_r == exp_spr)
      else begin
         errors++;
         $display("Mismatch spr_dat_o: got %h, expected %h", spr_dat_r, exp_spr);
      end

   a_ack_stb: assert property (@(posedge clk) disable iff (rst)
      spr_ack |-> spr_stb)
      else begin
         errors++;
         $display("SPR ack was high while the strobe was low");
      end

   a_no_reload: assert property (@(posedge clk) disable iff (rst)
      chk_noreload |-> !reload_req && !reload_busy)
      else begin
         errors++;
         $display("Reload started although the page-table base is zero");
      end

   a_walk_addr: assert property (@(posedge clk) disable iff (rst)
      chk_walk && reload_req && reload_ack |->
         reload_addr == ((ack_count == 0) ? exp_ptr_addr : exp_pte_addr))
      else begin
         errors++;
         $display("Mismatch reload_addr_o: got %h, expected %h", reload_addr,
                  (ack_count == 0) ? exp_ptr_addr : exp_pte_addr);
      end

   a_walk_busy: assert property (@(posedge clk) disable iff (rst)
      chk_walk && ack_count < exp_acks |-> reload_busy)
      else begin
         errors++;
         $display("Reload busy dropped before the walk finished");
      end

   // A missing entry must not fault while the walker fills it
   a_pf_masked: assert property (@(posedge clk) disable iff (rst)
      reload_busy |-> !pagefault)
      else begin
         errors++;
         $display("Mismatch pagefault_o: got %h, expected %h", pagefault, 1'b0);
      end

   a_pf_clear: assert property (@(posedge clk) disable iff (rst)
      pf_clear |-> !reload_pf)
      else begin
         errors++;
         $display("Mismatch reload_pagefault_o: got %h, expected %h", reload_pf, 1'b0);
      end

   task automatic finish_run();
      $display("Errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   endtask

   task automatic report_timeout(input string what);
      timeouts++;
      $display("Timeout while waiting for %s", what);
      finish_run();
   endtask

   task automatic check_bit(input string name, input logic got, input logic want);
      assert (got === want)
      else begin
         errors++;
         $display("Mismatch %s: got %h, expected %h", name, got, want);
      end
   endtask

   // Hold the strobe through the ack cycle so its data is sampled
   task automatic spr_access(input logic [15:0] addr, input logic we,
                             input logic [31:0] data, input logic [31:0] exp_rd);
      int t;
      @(negedge clk);
      chk_spr   = !we;
      exp_spr   = exp_rd;
      spr_addr  = addr;
      spr_we    = we;
      spr_dat_w = data;
      spr_stb   = 1'b1;
      t = 0;
      do begin
         @(negedge clk);
         t++;
      end while (!spr_ack && t < 10);
      if (!spr_ack) begin
         report_timeout("SPR ack");
      end else begin
         @(negedge clk);
         spr_stb = 1'b0;
         spr_we  = 1'b0;
         chk_spr = 1'b0;
      end
   endtask

   task automatic spr_write(input logic [15:0] addr, input logic [31:0] data);
      spr_access(addr, 1'b1, data, 32'h0);
      if (addr >= `DMMU_MATCH_BASE && addr < `DMMU_MATCH_BASE + 16'd64)
         ref_match[addr[5:0]] = data;
      else if (addr >= `DMMU_TRANS_BASE && addr < `DMMU_TRANS_BASE + 16'd64)
         ref_trans[addr[5:0]] = data;
   endtask

   task automatic spr_read(input logic [15:0] addr, input logic [31:0] exp_rd);
      spr_access(addr, 1'b0, 32'h0, exp_rd);
   endtask

   task automatic write_pte(input logic [31:0] addr, input logic [31:0] data);
      @(negedge clk);
      mem_we   = 1'b1;
      mem_addr = addr;
      mem_data = data;
      ref_pt[addr[13:2]] = data;
      @(negedge clk);
      mem_we = 1'b0;
   endtask

   function automatic logic [31:0] trans_from_pte(input logic [31:0] pte);
      logic [31:0] t;
      t = '0;
      t[31:13] = pte[31:13];
      t[`DMMU_TR_SWE] = pte[`DMMU_PTE_W];
      t[`DMMU_TR_SRE] = 1'b1;
      t[`DMMU_TR_UWE] = pte[`DMMU_PTE_W] & pte[`DMMU_PTE_U];
      t[`DMMU_TR_URE] = pte[`DMMU_PTE_U];
      t[5:0] = pte[5:0];
      return t;
   endfunction

   // Expected stage-two results from the reference TLB
   function automatic void set_expect(input logic [31:0] va, input logic l, input logic s,
                                      input logic sp);
      logic [5:0]  set;
      logic        hit;
      logic [31:0] tr;
      set = va[18:13];
      hit = ref_match[set][0] && (ref_match[set][31:13] == va[31:13]);
      tr  = hit ? ref_trans[set] : 32'h0;
      exp_miss = !hit;
      exp_phys = hit ? {tr[31:13], va[12:0]} : {19'd0, va[12:0]};
      exp_ci   = tr[`DMMU_TR_CI];
      if (sp)
         exp_pf = (s && !tr[`DMMU_TR_SWE]) || (l && !tr[`DMMU_TR_SRE]);
      else
         exp_pf = (s && !tr[`DMMU_TR_UWE]) || (l && !tr[`DMMU_TR_URE]);
      chk_lookup = 1'b1;
   endfunction

   task automatic lookup(input logic [31:0] va, input logic l, input logic s,
                         input logic sp);
      @(negedge clk);
      virt_addr = va;
      op_load   = 1'b0;
      op_store  = 1'b0;
      @(negedge clk);
      virt_addr_match = va;
      op_load    = l;
      op_store   = s;
      supervisor = sp;
      set_expect(va, l, s, sp);
      @(negedge clk);
      chk_lookup = 1'b0;
      op_load    = 1'b0;
      op_store   = 1'b0;
   endtask

   // Leaves the load asserted in the first cycle with busy low
   task automatic run_walk(input logic [31:0] va, input int acks);
      logic [31:0] ptr;
      int          t;
      @(negedge clk);
      walk_clear   = 1'b1;
      virt_addr    = va;
      op_load      = 1'b0;
      op_store     = 1'b0;
      exp_ptr_addr = {base, va[31:24], 2'b00};
      ptr          = ref_pt[exp_ptr_addr[13:2]];
      exp_pte_addr = {ptr[31:13], va[23:13], 2'b00};
      @(negedge clk);
      walk_clear      = 1'b0;
      virt_addr_match = va;
      op_load         = 1'b1;
      supervisor      = 1'b1;
      exp_acks        = acks;
      chk_walk        = 1'b1;
      t = 0;
      do begin
         @(negedge clk);
         t++;
      end while (reload_busy && t < 200);
      chk_walk = 1'b0;
      if (reload_busy) begin
         report_timeout("reload walk to finish");
      end else begin
         assert (ack_count == acks)
         else begin
            errors++;
            $display("Mismatch reload ack count: got %h, expected %h", ack_count, acks);
         end
      end
   endtask

   initial begin
      logic [31:0] va;
      logic [31:0] data;
      logic [31:0] pte;
      logic [5:0]  s;
      logic [31:0] vas [16];

      void'($urandom(31807));
      rst             = 1'b1;
      enable          = 1'b1;
      virt_addr       = '0;
      virt_addr_match = '0;
      op_load         = 1'b0;
      op_store        = 1'b0;
      supervisor      = 1'b1;
      spr_addr        = '0;
      spr_we          = 1'b0;
      spr_stb         = 1'b0;
      spr_dat_w       = '0;
      pf_clear        = 1'b0;
      mem_we          = 1'b0;
      mem_addr        = '0;
      mem_data        = '0;
      base            = '0;
      repeat (8) @(negedge clk);
      rst = 1'b0;

      // SPR write and read-back
      for (int i = 0; i < 8; i++) begin
         s = 6'($urandom);
         spr_write(`DMMU_MATCH_BASE + {10'd0, s}, $urandom);
         spr_write(`DMMU_TRANS_BASE + {10'd0, s}, $urandom);
         spr_read(`DMMU_MATCH_BASE + {10'd0, s}, ref_match[s]);
         spr_read(`DMMU_TRANS_BASE + {10'd0, s}, ref_trans[s]);
      end
      data = $urandom;
      spr_write(`DMMU_DMMUCR_ADDR, data);
      spr_read(`DMMU_DMMUCR_ADDR, data);
      spr_write(`DMMU_DMMUCR_ADDR, 32'h0);
      spr_read(`DMMU_DMMUCR_ADDR, 32'h0);
      spr_read(16'h0900, 32'h0);

      // Hits with every permission pattern, both modes, loads and stores
      for (int i = 0; i < 16; i++) begin
         va     = $urandom;
         vas[i] = va;
         s      = va[18:13];
         data   = $urandom;
         spr_write(`DMMU_MATCH_BASE + {10'd0, s}, {va[31:13], 12'd0, 1'b1});
         spr_write(`DMMU_TRANS_BASE + {10'd0, s},
                   {data[31:13], 3'b000, 4'(i), data[5:0]});
      end
      for (int i = 0; i < 16; i++) begin
         for (int m = 0; m < 4; m++) begin
            va = {vas[i][31:13], 13'($urandom)};
            lookup(va, !m[0], m[0], m[1]);
         end
      end

      // Misses with a zero base start no walk
      chk_noreload = 1'b1;
      lookup(vas[3] ^ 32'h8000_0000, 1'b1, 1'b0, 1'b1);
      s = vas[5][18:13];
      spr_write(`DMMU_MATCH_BASE + {10'd0, s}, {vas[5][31:13], 12'd0, 1'b0});
      lookup(vas[5], 1'b0, 1'b1, 1'b0);
      chk_noreload = 1'b0;

      // Hardware reload of mapped pages
      spr_write(`DMMU_DMMUCR_ADDR, 32'h0000_0400);
      base = 22'd1;
      for (int k = 0; k < 4; k++) begin
         va = $urandom;
         s  = va[18:13];
         spr_write(`DMMU_MATCH_BASE + {10'd0, s}, 32'h0);
         write_pte(32'h400 + {22'd0, va[31:24], 2'b00}, 32'h0000_2000);
         pte = $urandom;
         pte[`DMMU_PTE_PRESENT] = 1'b1;
         write_pte(32'h2000 + {19'd0, va[23:13], 2'b00}, pte);
         run_walk(va, 2);
         ref_match[s] = {va[31:13], 12'd0, 1'b1};
         ref_trans[s] = trans_from_pte(pte);
         set_expect(va, 1'b1, 1'b0, 1'b1);
         @(negedge clk);
         chk_lookup = 1'b0;
         op_load    = 1'b0;
         spr_read(`DMMU_MATCH_BASE + {10'd0, s}, ref_match[s]);
         spr_read(`DMMU_TRANS_BASE + {10'd0, s}, ref_trans[s]);
      end

      // Zero pointer, huge pointer, absent page
      for (int f = 0; f < 3; f++) begin
         va = $urandom;
         s  = va[18:13];
         spr_write(`DMMU_MATCH_BASE + {10'd0, s}, 32'h0);
         write_pte(32'h400 + {22'd0, va[31:24], 2'b00},
                   (f == 0) ? 32'h0 : (f == 1) ? 32'h0000_2200 : 32'h0000_2000);
         if (f == 2) begin
            pte = $urandom;
            pte[`DMMU_PTE_PRESENT] = 1'b0;
            write_pte(32'h2000 + {19'd0, va[23:13], 2'b00}, pte);
         end
         run_walk(va, (f == 2) ? 2 : 1);
         check_bit("reload_pagefault_o", reload_pf, 1'b1);
         set_expect(va, 1'b1, 1'b0, 1'b1);
         @(negedge clk);
         chk_lookup = 1'b0;
         op_load    = 1'b0;
         @(negedge clk);
         pf_clear = 1'b1;
         @(negedge clk);
         pf_clear = 1'b0;
         check_bit("reload_pagefault_o", reload_pf, 1'b0);
      end

      repeat (2) @(negedge clk);
      finish_run();
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+rtl
rtl/dmmu_pkg.sv
rtl/dmmu_tlb_ram.sv
rtl/dmmu_spr_if.sv
rtl/dmmu_lookup.sv
rtl/dmmu_reload_ctrl.sv
rtl/dmmu_top.sv
test/tb_pte_mem.sv
test/tb_dmmu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the data MMU testbench with Verilator, run it and scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module tb_dmmu -f filelist.f -o tb_dmmu_sim \
   && ./obj_dir/tb_dmmu_sim | tee sim.log \
   || { echo "Build or simulation run failed"; exit 1; }

grep -q "TEST FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "No pass result in sim.log"; exit 1; }
exit 0
